/* sources.f */
+incdir+hw
hw/z8Pkg.sv
hw/programRom.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/registerFile.sv
hw/alu.sv
hw/executeStage.sv
hw/z8Core.sv
sim/tbClock.sv
sim/z8CoreTb.sv

/* Makefile */
# Verilator build for the z8Core testbench

VERILATOR ?= verilator
TOP       ?= z8CoreTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= TEST PASS
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(wildcard hw/*.sv hw/*.svh sim/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/z8CoreTb.sv */
`include "core_params.svh"
`timescale 1ns/1ns
`default_nettype none

module z8CoreTb;
    localparam int MaxRows = 64;
    localparam int ProgBytes = 16;
    localparam int SettleCycles = 40;
    localparam logic [7:0] Taken = 8'hA5;
    localparam logic [7:0] NotTaken = 8'h5A;

    logic                         clk;
    logic                         rst;
    logic                         loadEn;
    logic [`Z8_ROM_ADDR_BITS-1:0] loadAddr;
    logic [7:0]                   loadData;
    logic [7:0]                   port2;

    // one row per test
    string      testName [MaxRows];
    logic [7:0] progMem [MaxRows][ProgBytes];
    logic [7:0] expectPort [MaxRows];
    int         budget [MaxRows];
    int         rowCount = 0;
    logic [7:0] rowBytes [$];

    int failCount = 0;
    int passCount = 0;
    int watchdogCycles = 0;

    logic [3:0] binaryOps [10] = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'hA, 4'hB};
    string binaryNames [10] = '{"add", "adc", "sub", "sbc", "or", "and", "tcm", "tm", "cp", "xor"};
    logic [3:0] unaryOps [10] = '{4'h0, 4'h1, 4'h2, 4'h6, 4'h9, 4'hB, 4'hC, 4'hD, 4'hE, 4'hF};
    string unaryNames [10] = '{"dec", "rlc", "inc", "com", "rl", "clr", "rrc", "sra", "rr", "swap"};
    // rcf, scf, ccf
    logic [7:0] flagOps [3] = '{8'hCF, 8'hDF, 8'hEF};

    tbClock #(.PeriodNs(4)) clockGen (.clk(clk));

    z8Core DUT (
        .clk(clk),
        .rst(rst),
        .loadEn(loadEn),
        .loadAddr(loadAddr),
        .loadData(loadData),
        .port2(port2)
    );

    function automatic logic [7:0] randByte();
        return 8'($urandom);
    endfunction

    function automatic logic carryAfter(input logic [7:0] fop, input logic c);
        case (fop)
            8'hCF: return 1'b0;
            8'hDF: return 1'b1;
            default: return ~c;
        endcase
    endfunction

    function automatic logic [7:0] binaryResult(input logic [3:0] op, input logic [7:0] a,
                                                input logic [7:0] b, input logic c);
        case (op)
            4'h0: return a + b;
            4'h1: return a + b + 8'(c);
            4'h2: return a - b;
            4'h3: return a - b - 8'(c);
            4'h4: return a | b;
            4'h5: return a & b;
            4'hB: return a ^ b;
            // tcm, tm and cp keep the destination
            default: return a;
        endcase
    endfunction

    function automatic logic [7:0] unaryResult(input logic [3:0] op, input logic [7:0] a,
                                               input logic c);
        case (op)
            4'h0: return a - 8'd1;
            4'h1: return {a[6:0], c};
            4'h2: return a + 8'd1;
            4'h6: return ~a;
            4'h9: return {a[6:0], a[7]};
            4'hB: return 8'h00;
            4'hC: return {c, a[7:1]};
            4'hD: return {a[7], a[7:1]};
            4'hE: return {a[0], a[7:1]};
            default: return {a[3:0], a[7:4]};
        endcase
    endfunction

    // branch outcome after cp a,b, taken from the compared values themselves
    function automatic logic conditionHolds(input logic [3:0] cc, input logic [7:0] a,
                                            input logic [7:0] b);
        int         sa;
        int         sb;
        logic [7:0] diff;
        logic       signedLess;
        logic       overflow;
        logic       base;
        sa = int'($signed(a));
        sb = int'($signed(b));
        diff = a - b;
        signedLess = sa < sb;
        overflow = (sa - sb > 127) || (sa - sb < -128);
        case (cc[2:0])
            3'd0: base = 1'b0;
            3'd1: base = signedLess;
            3'd2: base = signedLess || (a == b);
            3'd3: base = a <= b;
            3'd4: base = overflow;
            3'd5: base = diff[7];
            3'd6: base = a == b;
            default: base = a < b;
        endcase
        return base ^ cc[3];
    endfunction

    task automatic emitInstr(input int len, input logic [7:0] b0,
                             input logic [7:0] b1 = 8'h00, input logic [7:0] b2 = 8'h00);
        rowBytes.push_back(b0);
        if (len > 1) begin
            rowBytes.push_back(b1);
        end
        if (len > 2) begin
            rowBytes.push_back(b2);
        end
    endtask

    task automatic finishRow(input string name, input logic [7:0] expected, input int extra);
        // park on jr to itself
        emitInstr(2, 8'h8B, 8'hFE);
        if (rowBytes.size() > ProgBytes || rowCount >= MaxRows) begin
            $display("test table: program %s does not fit", name);
            failCount++;
        end else begin
            for (int i = 0; i < ProgBytes; i++) begin
                progMem[rowCount][i] = (i < rowBytes.size()) ? rowBytes[i] : 8'hFF;
            end
            testName[rowCount] = name;
            expectPort[rowCount] = expected;
            budget[rowCount] = 4 * rowBytes.size() + extra;
            rowCount++;
        end
        rowBytes.delete();
    endtask

    // ld r4,#a then cp r4,#b
    task automatic emitCompare(input logic [7:0] a, input logic [7:0] b);
        emitInstr(2, 8'h4C, a);
        emitInstr(3, 8'hA6, 8'hE4, b);
    endtask

    task automatic emitPaths();
        emitInstr(2, 8'h2C, NotTaken);
        emitInstr(2, 8'h8B, 8'hFE);
        emitInstr(2, 8'h2C, Taken);
    endtask

    task automatic buildTable();
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] fop;
        logic       c;
        logic [3:0] cc;
        logic [3:0] rpHigh;
        logic [7:0] count;

        a = randByte() | 8'h01;
        emitInstr(3, 8'hE6, `Z8_REG_PORT2, a);
        finishRow("ld 02,#imm", a, 16);
        a = randByte() | 8'h01;
        emitInstr(2, 8'h31, 8'h00);
        emitInstr(2, 8'h2C, a);
        finishRow("srp 00, ld r2", a, 16);
        // r2 lands outside the port
        a = randByte() | 8'h01;
        rpHigh = 4'($urandom_range(7, 1));
        emitInstr(2, 8'h31, {rpHigh, 4'h0});
        emitInstr(2, 8'h2C, a);
        finishRow("srp nonzero, ld r2", 8'h00, 16);

        for (int k = 0; k < 10; k++) begin
            a = randByte();
            b = randByte();
            fop = flagOps[$urandom_range(2, 0)];
            c = carryAfter(fop, 1'b0);
            emitInstr(1, fop);
            emitInstr(2, 8'h4C, a);
            emitInstr(2, 8'h5C, b);
            emitInstr(2, {binaryOps[k], 4'h2}, 8'h45);
            emitInstr(3, 8'hE4, 8'h04, `Z8_REG_PORT2);
            finishRow({binaryNames[k], " r4,r5"}, binaryResult(binaryOps[k], a, b, c), 16);

            a = randByte();
            b = randByte();
            fop = flagOps[$urandom_range(2, 0)];
            c = carryAfter(fop, 1'b0);
            emitInstr(1, fop);
            emitInstr(3, 8'hE6, 8'h10, a);
            emitInstr(3, {binaryOps[k], 4'h6}, 8'h10, b);
            emitInstr(3, 8'hE4, 8'h10, `Z8_REG_PORT2);
            finishRow({binaryNames[k], " 10,#imm"}, binaryResult(binaryOps[k], a, b, c), 16);
        end

        for (int k = 0; k < 10; k++) begin
            a = randByte();
            fop = flagOps[$urandom_range(2, 0)];
            c = carryAfter(fop, 1'b0);
            emitInstr(1, fop);
            emitInstr(3, 8'hE6, 8'h10, a);
            emitInstr(2, {unaryOps[k], 4'h0}, 8'h10);
            emitInstr(3, 8'hE4, 8'h10, `Z8_REG_PORT2);
            finishRow({unaryNames[k], " 10"}, unaryResult(unaryOps[k], a, c), 16);
        end
        a = randByte();
        emitInstr(2, 8'h4C, a);
        emitInstr(1, 8'h4E);
        emitInstr(3, 8'hE4, 8'h04, `Z8_REG_PORT2);
        finishRow("inc r4", a + 8'd1, 16);

        // every condition code once, some with equal operands
        for (int k = 0; k < 16; k++) begin
            cc = 4'(k);
            a = randByte();
            b = ($urandom_range(3, 0) == 0) ? a : randByte();
            emitCompare(a, b);
            emitInstr(2, {cc, 4'hB}, 8'h04);
            emitPaths();
            finishRow($sformatf("jr cc=%h", cc), conditionHolds(cc, a, b) ? Taken : NotTaken, 16);
        end
        for (int k = 0; k < 4; k++) begin
            cc = 4'($urandom_range(15, 0));
            a = randByte();
            b = randByte();
            emitCompare(a, b);
            emitInstr(3, {cc, 4'hD}, 8'h00, 8'h18);
            emitPaths();
            finishRow($sformatf("jp cc=%h", cc), conditionHolds(cc, a, b) ? Taken : NotTaken, 16);
        end

        // one inc and one djnz per pass
        count = 8'($urandom_range(20, 1));
        emitInstr(3, 8'hE6, `Z8_REG_PORT2, 8'h00);
        emitInstr(2, 8'h3C, count);
        emitInstr(1, 8'h2E);
        emitInstr(2, 8'h3A, 8'hFD);
        finishRow("djnz loop", count, 9 * int'(count) + 16);
    endtask

    task automatic checkPort(input logic [7:0] actual, input logic [7:0] expected,
                             output logic ok);
        ok = (actual === expected);
        if (!ok) begin
            $display("Mismatch at %0t ns: port2 is %02h, expected %02h",
                     $time, actual, expected);
        end
    endtask

    task automatic runRow(input int idx);
        logic        ok;
        logic        rowOk;
        logic [15:0] fullAddr;
        int          cycles;
        rowOk = 1'b1;
        rst = 1'b1;
        loadEn = 1'b0;
        repeat (4) @(negedge clk);
        checkPort(port2, 8'h00, ok);
        rowOk &= ok;
        // program goes in while the core sits in reset
        for (int i = 0; i < ProgBytes; i++) begin
            fullAddr = `Z8_RESET_PC + 16'(i);
            loadEn = 1'b1;
            loadAddr = fullAddr[`Z8_ROM_ADDR_BITS-1:0];
            loadData = progMem[idx][i];
            @(negedge clk);
        end
        loadEn = 1'b0;
        rst = 1'b0;
        cycles = 0;
        while (port2 !== expectPort[idx] && cycles < budget[idx]) begin
            @(negedge clk);
            cycles++;
        end
        if (port2 !== expectPort[idx]) begin
            $display("row %0d %s: port2 did not reach %02h within %0d cycles",
                     idx, testName[idx], expectPort[idx], budget[idx]);
        end else begin
            // later instructions must not move the port
            repeat (SettleCycles) @(negedge clk);
        end
        checkPort(port2, expectPort[idx], ok);
        rowOk &= ok;
        if (rowOk) begin
            passCount++;
            $display("row %0d %s: passed", idx, testName[idx]);
        end else begin
            failCount++;
            $display("row %0d %s: failed", idx, testName[idx]);
        end
    endtask

    initial begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", watchdogCycles);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int total;
        rst = 1'b1;
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        void'($urandom(32'hf2db_dbc2));
        buildTable();
        total = 0;
        for (int i = 0; i < rowCount; i++) begin
            total += budget[i] + 4 + ProgBytes + SettleCycles + 2;
        end
        watchdogCycles = 2 * total;
        for (int i = 0; i < rowCount; i++) begin
            runRow(i);
        end
        $display("rows run %0d, passed %0d, failed %0d", rowCount, passCount, failCount);
        if (failCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end
endmodule

`default_nettype wire

/* sim/tbClock.sv */
`timescale 1ns/1ns
`default_nettype none

module tbClock #(
    parameter int PeriodNs = 4
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always begin
        #(PeriodNs / 2) clk = ~clk;
    end
endmodule

`default_nettype wire

/* hw/z8Core.sv */
`include "core_params.svh"
`timescale 1ns/1ns
`default_nettype none

module z8Core (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          loadEn,
    input  logic [`Z8_ROM_ADDR_BITS-1:0]  loadAddr,
    input  logic [7:0]                    loadData,
    output logic [7:0]                    port2
);
    import z8Pkg::*;

    logic [`Z8_ROM_ADDR_BITS-1:0] romAddr;
    logic [7:0]                   romData;
    logic                         instrValid;
    logic [7:0]                   opcode;
    operandByte_u                 second;
    logic [7:0]                   third;
    logic [15:0]                  pc;
    logic [7:0]                   rdAddrA;
    logic [7:0]                   rdAddrB;
    logic [7:0]                   rdDataA;
    logic [7:0]                   rdDataB;
    logic [3:0]                   rp;
    logic                         opValid;
    execKind_e                    kind;
    aluOp_e                       aluOp;
    logic [7:0]                   opA;
    logic [7:0]                   opB;
    logic                         writeEn;
    logic [7:0]                   writeAddr;
    logic [3:0]                   cond;
    logic [15:0]                  target;
    logic                         regWrite;
    logic [7:0]                   regWriteAddr;
    logic [7:0]                   regWriteData;
    logic                         execDone;
    logic                         redirect;
    logic [15:0]                  redirectPc;

    programRom rom (
        .clk(clk),
        .loadEn(loadEn),
        .loadAddr(loadAddr),
        .loadData(loadData),
        .addr(romAddr),
        .data(romData)
    );

    fetchStage fetch (
        .clk(clk),
        .rst(rst),
        .romData(romData),
        .execDone(execDone),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .romAddr(romAddr),
        .instrValid(instrValid),
        .opcode(opcode),
        .second(second),
        .third(third),
        .pc(pc)
    );

    decodeStage decode (
        .clk(clk),
        .rst(rst),
        .instrValid(instrValid),
        .opcode(opcode),
        .second(second),
        .third(third),
        .rp(rp),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .rdAddrA(rdAddrA),
        .rdAddrB(rdAddrB),
        .opValid(opValid),
        .kind(kind),
        .aluOp(aluOp),
        .opA(opA),
        .opB(opB),
        .writeEn(writeEn),
        .writeAddr(writeAddr),
        .cond(cond),
        .target(target)
    );

    registerFile regs (
        .clk(clk),
        .rst(rst),
        .rdAddrA(rdAddrA),
        .rdAddrB(rdAddrB),
        .write(regWrite),
        .writeAddr(regWriteAddr),
        .writeData(regWriteData),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .rp(rp),
        .port2(port2)
    );

    executeStage execute (
        .clk(clk),
        .rst(rst),
        .opValid(opValid),
        .kind(kind),
        .aluOp(aluOp),
        .opA(opA),
        .opB(opB),
        .writeEn(writeEn),
        .writeAddr(writeAddr),
        .cond(cond),
        .target(target),
        .pc(pc),
        .regWrite(regWrite),
        .regWriteAddr(regWriteAddr),
        .regWriteData(regWriteData),
        .execDone(execDone),
        .redirect(redirect),
        .redirectPc(redirectPc)
    );
endmodule

`default_nettype wire

/* hw/executeStage.sv */
`timescale 1ns/1ns
`default_nettype none

module executeStage (
    input  logic              clk,
    input  logic              rst,
    input  logic              opValid,
    input  z8Pkg::execKind_e  kind,
    input  z8Pkg::aluOp_e     aluOp,
    input  logic [7:0]        opA,
    input  logic [7:0]        opB,
    input  logic              writeEn,
    input  logic [7:0]        writeAddr,
    input  logic [3:0]        cond,
    input  logic [15:0]       target,
    input  logic [15:0]       pc,
    output logic              regWrite,
    output logic [7:0]        regWriteAddr,
    output logic [7:0]        regWriteData,
    output logic              execDone,
    output logic              redirect,
    output logic [15:0]       redirectPc
);
    import z8Pkg::*;

    flags_t     flags;
    flags_t     aluFlags;
    logic [7:0] result;
    logic       taken;

    alu aluInst (
        .op(aluOp),
        .a(opA),
        .b(opB),
        .flagsIn(flags),
        .result(result),
        .flagsOut(aluFlags)
    );

    // eight base conditions, high bit inverts
    function automatic logic condMet(input flags_t f, input logic [3:0] cc);
        logic base;
        case (cc[2:0])
            3'd0: base = 1'b0;
            3'd1: base = f.s ^ f.v;
            3'd2: base = (f.s ^ f.v) | f.z;
            3'd3: base = f.c | f.z;
            3'd4: base = f.v;
            3'd5: base = f.s;
            3'd6: base = f.z;
            default: base = f.c;
        endcase
        return base ^ cc[3];
    endfunction

    always_comb begin
        case (kind)
            execJumpRel, execJumpAbs: taken = condMet(flags, cond);
            execDjnz: taken = (result != 8'h00);
            default: taken = 1'b0;
        endcase
    end

    assign execDone = opValid;
    assign redirect = opValid & taken;
    // pc already points past the instruction
    assign redirectPc = (kind == execJumpAbs) ? target : pc + target;
    assign regWrite = opValid & writeEn;
    assign regWriteAddr = writeAddr;
    assign regWriteData = result;

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (opValid) begin
            if (kind == execAlu) begin
                flags <= aluFlags;
            end else if (kind == execFlagOp) begin
                case (cond)
                    4'hC: flags.c <= 1'b0;
                    4'hD: flags.c <= 1'b1;
                    default: flags.c <= ~flags.c;
                endcase
            end
        end
    end
endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  z8Pkg::aluOp_e   op,
    input  logic [7:0]      a,
    input  logic [7:0]      b,
    input  z8Pkg::flags_t   flagsIn,
    output logic [7:0]      result,
    output z8Pkg::flags_t   flagsOut
);
    import z8Pkg::*;

    logic       cin;
    logic [8:0] sum;
    logic [8:0] diff;

    // carry in only for adc and sbc, bit 8 of diff is the borrow
    assign cin = flagsIn.c & (op == aluAdc || op == aluSbc);
    assign sum = {1'b0, a} + {1'b0, b} + {8'h00, cin};
    assign diff = {1'b0, a} - {1'b0, b} - {8'h00, cin};

    always_comb begin
        flagsOut = flagsIn;
        case (op)
            aluAdd, aluAdc: begin
                result = sum[7:0];
                flagsOut.c = sum[8];
                flagsOut.v = (a[7] == b[7]) && (result[7] != a[7]);
            end
            aluSub, aluSbc, aluCp: begin
                result = diff[7:0];
                flagsOut.c = diff[8];
                flagsOut.v = (a[7] != b[7]) && (result[7] != a[7]);
            end
            aluOr: result = a | b;
            aluAnd, aluTm: result = a & b;
            aluTcm: result = ~a & b;
            aluXor: result = a ^ b;
            aluCom: result = ~a;
            aluInc: begin
                result = a + 8'd1;
                flagsOut.v = (a == 8'h7F);
            end
            aluDec: begin
                result = a - 8'd1;
                flagsOut.v = (a == 8'h80);
            end
            aluRlc: begin
                result = {a[6:0], flagsIn.c};
                flagsOut.c = a[7];
            end
            aluRl: begin
                result = {a[6:0], a[7]};
                flagsOut.c = a[7];
            end
            aluRrc: begin
                result = {flagsIn.c, a[7:1]};
                flagsOut.c = a[0];
            end
            aluRr: begin
                result = {a[0], a[7:1]};
                flagsOut.c = a[0];
            end
            aluSra: begin
                result = {a[7], a[7:1]};
                flagsOut.c = a[0];
            end
            aluSwap: result = {a[3:0], a[7:4]};
            aluClr: result = 8'h00;
            default: result = b;
        endcase

        case (op)
            aluOr, aluAnd, aluTm, aluTcm, aluXor, aluCom, aluSra: flagsOut.v = 1'b0;
            // rotates flag a sign change
            aluRlc, aluRl, aluRrc, aluRr: flagsOut.v = a[7] ^ result[7];
            default: begin
            end
        endcase

        if (op != aluLd && op != aluClr) begin
            flagsOut.z = (result == 8'h00);
            flagsOut.s = result[7];
        end
    end
endmodule

`default_nettype wire

/* hw/registerFile.sv */
`include "core_params.svh"
`timescale 1ns/1ns
`default_nettype none

module registerFile (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  rdAddrA,
    input  logic [7:0]  rdAddrB,
    input  logic        write,
    input  logic [7:0]  writeAddr,
    input  logic [7:0]  writeData,
    output logic [7:0]  rdDataA,
    output logic [7:0]  rdDataB,
    output logic [3:0]  rp,
    output logic [7:0]  port2
);
    localparam int IdxBits = $clog2(`Z8_REG_COUNT);

    logic [7:0] regs [0:`Z8_REG_COUNT-1];

    function automatic logic [7:0] readReg(input logic [7:0] a);
        if (a < `Z8_REG_COUNT) begin
            return regs[a[IdxBits-1:0]];
        end else if (a == `Z8_REG_RP) begin
            return {rp, 4'h0};
        end
        return 8'h00;
    endfunction

    assign rdDataA = readReg(rdAddrA);
    assign rdDataB = readReg(rdAddrB);

    always_ff @(posedge clk) begin
        if (write && writeAddr < `Z8_REG_COUNT) begin
            regs[writeAddr[IdxBits-1:0]] <= writeData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rp <= 4'h0;
            port2 <= 8'h00;
        end else if (write) begin
            if (writeAddr == `Z8_REG_RP) begin
                rp <= writeData[7:4];
            end
            if (writeAddr == `Z8_REG_PORT2) begin
                port2 <= writeData;
            end
        end
    end
endmodule

`default_nettype wire

/* hw/decodeStage.sv */
`include "core_params.svh"
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instrValid,
    input  logic [7:0]           opcode,
    input  z8Pkg::operandByte_u  second,
    input  logic [7:0]           third,
    input  logic [3:0]           rp,
    input  logic [7:0]           rdDataA,
    input  logic [7:0]           rdDataB,
    output logic [7:0]           rdAddrA,
    output logic [7:0]           rdAddrB,
    output logic                 opValid,
    output z8Pkg::execKind_e     kind,
    output z8Pkg::aluOp_e        aluOp,
    output logic [7:0]           opA,
    output logic [7:0]           opB,
    output logic                 writeEn,
    output logic [7:0]           writeAddr,
    output logic [3:0]           cond,
    output logic [15:0]          target
);
    import z8Pkg::*;

    logic [3:0] hi;
    logic [3:0] col;

    assign hi = opcode[7:4];
    assign col = opcode[3:0];

    // working register group maps through rp
    function automatic logic [7:0] expand(input logic [7:0] a);
        return (a[7:4] == `Z8_WORKING_GROUP) ? {rp, a[3:0]} : a;
    endfunction

    function automatic logic isUnary(input logic [3:0] h);
        case (h)
            4'h0, 4'h1, 4'h2, 4'h6, 4'h9, 4'hB, 4'hC, 4'hD, 4'hE, 4'hF: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic isBinary(input logic [3:0] h);
        return (h[3] == 1'b0) || (h == 4'hA) || (h == 4'hB);
    endfunction

    // cp, tm and tcm only set flags
    function automatic logic stores(input logic [3:0] h);
        return (h[3:2] == 2'b00) || (h[3:1] == 3'b010) || (h == 4'hB);
    endfunction

    always_comb begin
        case (col)
            4'h0, 4'h6: rdAddrA = expand(second.regAddr);
            4'h2: rdAddrA = {rp, second.nib.hi};
            4'h4: rdAddrA = expand(third);
            default: rdAddrA = {rp, hi};
        endcase
        rdAddrB = (col == 4'h2) ? {rp, second.nib.lo} : expand(second.regAddr);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            opValid <= 1'b0;
        end else begin
            opValid <= instrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            kind <= execNone;
            aluOp <= aluLd;
            opA <= rdDataA;
            opB <= rdDataB;
            writeEn <= 1'b0;
            writeAddr <= rdAddrA;
            cond <= hi;
            target <= {{8{second.regAddr[7]}}, second.regAddr};
            case (col)
                4'h0: begin
                    if (isUnary(hi)) begin
                        kind <= execAlu;
                        aluOp <= aluOp_e'({1'b0, hi});
                        writeEn <= 1'b1;
                    end
                end
                4'h1: begin
                    // srp
                    if (hi == 4'h3) begin
                        kind <= execAlu;
                        opB <= second.regAddr;
                        writeAddr <= `Z8_REG_RP;
                        writeEn <= 1'b1;
                    end
                end
                4'h2: begin
                    if (isBinary(hi)) begin
                        kind <= execAlu;
                        aluOp <= aluOp_e'({1'b1, hi});
                        writeEn <= stores(hi);
                    end
                end
                4'h4: begin
                    if (hi == 4'hE) begin
                        kind <= execAlu;
                        writeEn <= 1'b1;
                    end
                end
                4'h6: begin
                    opB <= third;
                    if (hi == 4'hE) begin
                        kind <= execAlu;
                        writeEn <= 1'b1;
                    end else if (isBinary(hi)) begin
                        kind <= execAlu;
                        aluOp <= aluOp_e'({1'b1, hi});
                        writeEn <= stores(hi);
                    end
                end
                4'hA: begin
                    kind <= execDjnz;
                    aluOp <= aluDec;
                    writeEn <= 1'b1;
                end
                4'hB: kind <= execJumpRel;
                4'hC: begin
                    kind <= execAlu;
                    opB <= second.regAddr;
                    writeEn <= 1'b1;
                end
                4'hD: begin
                    kind <= execJumpAbs;
                    target <= {second.regAddr, third};
                end
                4'hE: begin
                    kind <= execAlu;
                    aluOp <= aluInc;
                    writeEn <= 1'b1;
                end
                4'hF: begin
                    // rcf, scf, ccf
                    if (hi >= 4'hC && hi <= 4'hE) begin
                        kind <= execFlagOp;
                    end
                end
                default: begin
                end
            endcase
        end
    end
endmodule

`default_nettype wire

/* hw/fetchStage.sv */
`include "core_params.svh"
`timescale 1ns/1ns
`default_nettype none

module fetchStage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [7:0]                    romData,
    input  logic                          execDone,
    input  logic                          redirect,
    input  logic [15:0]                   redirectPc,
    output logic [`Z8_ROM_ADDR_BITS-1:0]  romAddr,
    output logic                          instrValid,
    output logic [7:0]                    opcode,
    output z8Pkg::operandByte_u           second,
    output logic [7:0]                    third,
    output logic [15:0]                   pc
);
    localparam logic [2:0] StRequest = 3'd0;
    localparam logic [2:0] StByte1 = 3'd1;
    localparam logic [2:0] StByte2 = 3'd2;
    localparam logic [2:0] StByte3 = 3'd3;
    localparam logic [2:0] StIdle = 3'd4;

    logic [2:0] state;

    // byte count by opcode column
    function automatic logic [1:0] instrLength(input logic [7:0] op);
        if (op[3:1] == 3'b111) begin
            return 2'd1;
        end else if (op[3:2] == 2'b01 || op[3:0] == 4'hD) begin
            return 2'd3;
        end
        return 2'd2;
    endfunction

    assign romAddr = pc[`Z8_ROM_ADDR_BITS-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= StRequest;
            pc <= `Z8_RESET_PC;
            instrValid <= 1'b0;
        end else begin
            instrValid <= 1'b0;
            case (state)
                StRequest: begin
                    pc <= pc + 16'd1;
                    state <= StByte1;
                end
                StByte1: begin
                    if (instrLength(romData) == 2'd1) begin
                        instrValid <= 1'b1;
                        state <= StIdle;
                    end else begin
                        pc <= pc + 16'd1;
                        state <= StByte2;
                    end
                end
                StByte2: begin
                    if (instrLength(opcode) == 2'd2) begin
                        instrValid <= 1'b1;
                        state <= StIdle;
                    end else begin
                        pc <= pc + 16'd1;
                        state <= StByte3;
                    end
                end
                StByte3: begin
                    instrValid <= 1'b1;
                    state <= StIdle;
                end
                default: begin
                    // wait for execute, then restart at the next or branch pc
                    if (execDone) begin
                        if (redirect) begin
                            pc <= redirectPc;
                        end
                        state <= StRequest;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == StByte1) begin
            opcode <= romData;
        end
        if (state == StByte2) begin
            second <= romData;
        end
        if (state == StByte3) begin
            third <= romData;
        end
    end
endmodule

`default_nettype wire

/* hw/programRom.sv */
`include "core_params.svh"
`timescale 1ns/1ns
`default_nettype none

module programRom (
    input  logic                          clk,
    input  logic                          loadEn,
    input  logic [`Z8_ROM_ADDR_BITS-1:0]  loadAddr,
    input  logic [7:0]                    loadData,
    input  logic [`Z8_ROM_ADDR_BITS-1:0]  addr,
    output logic [7:0]                    data
);
    logic [7:0] mem [0:(1 << `Z8_ROM_ADDR_BITS)-1];

    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;
        end
        data <= mem[addr];
    end
endmodule

`default_nettype wire

/* hw/z8Pkg.sv */
`default_nettype none

package z8Pkg;

    // one-operand ops use {0, high nibble}, two-operand ops {1, high nibble}
    typedef enum logic [4:0] {
        aluDec  = 5'h00,
        aluRlc  = 5'h01,
        aluInc  = 5'h02,
        aluCom  = 5'h06,
        aluLd   = 5'h08,
        aluRl   = 5'h09,
        aluClr  = 5'h0B,
        aluRrc  = 5'h0C,
        aluSra  = 5'h0D,
        aluRr   = 5'h0E,
        aluSwap = 5'h0F,
        aluAdd  = 5'h10,
        aluAdc  = 5'h11,
        aluSub  = 5'h12,
        aluSbc  = 5'h13,
        aluOr   = 5'h14,
        aluAnd  = 5'h15,
        aluTcm  = 5'h16,
        aluTm   = 5'h17,
        aluCp   = 5'h1A,
        aluXor  = 5'h1B
    } aluOp_e;

    // bit order of the Z8 flags register
    typedef struct packed {
        logic       c;
        logic       z;
        logic       s;
        logic       v;
        logic       d;
        logic       h;
        logic [1:0] unused;
    } flags_t;

    // R operand or a pair of working registers r,r
    typedef union packed {
        logic [7:0] regAddr;
        struct packed {
            logic [3:0] hi;
            logic [3:0] lo;
        } nib;
    } operandByte_u;

    typedef enum logic [2:0] {
        execNone    = 3'd0,
        execAlu     = 3'd1,
        execJumpRel = 3'd2,
        execJumpAbs = 3'd3,
        execDjnz    = 3'd4,
        execFlagOp  = 3'd5
    } execKind_e;

endpackage

`default_nettype wire

/* hw/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH
`default_nettype none

// start address after reset
`define Z8_RESET_PC 16'h000C
`define Z8_ROM_ADDR_BITS 10
`define Z8_REG_COUNT 128

// special registers
`define Z8_REG_PORT2 8'h02
`define Z8_REG_RP 8'hFD
`define Z8_WORKING_GROUP 4'hE

`default_nettype wire
`endif
